//--- cache_cfg_pkg.sv
// cache geometry with address split, word and line widths and set count

package cache_cfg_pkg;

    // ------------------------------------------------------------------------
    // address and data widths
    // ------------------------------------------------------------------------
    // byte address from the core
    localparam int ADDR_W = 32;
    // one core data word
    localparam int WORD_W = 32;
    // one cache line of four words
    localparam int LINE_W = 128;

    // ------------------------------------------------------------------------
    // address split into tag, index and offset
    // ------------------------------------------------------------------------
    // byte offset inside a line
    localparam int OFFSET_W = $clog2(LINE_W / 8);
    // set index
    localparam int INDEX_W = 4;
    // tag takes whatever is left of the address
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // number of sets per way
    localparam int NUM_SETS = 2 ** INDEX_W;
    // words held by one line
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

endpackage

//--- cache_types_pkg.sv
// cache port and way payload structs shared by the controller and the ways

package cache_types_pkg;

    // core side load or store request held as a level until granted
    typedef struct packed {
        logic                                valid;
        logic                                we;
        logic [cache_cfg_pkg::ADDR_W-1:0]    addr;
        logic [cache_cfg_pkg::WORD_W/8-1:0]  be;
        logic [cache_cfg_pkg::WORD_W-1:0]    wdata;
    } core_req_t;

    // one cycle response pulse whose rdata is zero for stores
    typedef struct packed {
        logic                                valid;
        logic [cache_cfg_pkg::WORD_W-1:0]    rdata;
    } core_resp_t;

    // line request to memory held until the ack strobe
    typedef struct packed {
        logic                                                    valid;
        logic                                                    we;
        logic [cache_cfg_pkg::TAG_W+cache_cfg_pkg::INDEX_W-1:0]  line_addr;
        logic [cache_cfg_pkg::LINE_W-1:0]                        wline;
    } mem_req_t;

    // tag state of one set in one way
    typedef struct packed {
        logic                                valid;
        logic                                dirty;
        logic [cache_cfg_pkg::TAG_W-1:0]     tag;
    } tag_entry_t;

    // command broadcast to every way where only the enabled way writes
    typedef struct packed {
        logic [cache_cfg_pkg::INDEX_W-1:0]   index;
        logic [cache_cfg_pkg::TAG_W-1:0]     tag;
        logic [cache_cfg_pkg::LINE_W-1:0]    wline;
        logic [cache_cfg_pkg::LINE_W/8-1:0]  be;
        logic                                set_dirty;
        logic                                valid;
    } way_cmd_t;

    // lookup result of one way at the command index
    typedef struct packed {
        logic                                hit;
        tag_entry_t                          entry;
        logic [cache_cfg_pkg::LINE_W-1:0]    line;
    } way_resp_t;

endpackage

//--- cache_reg_array.sv
// register array with asynchronous read and one write port for any entry type
`timescale 1ns/1ps

module cache_reg_array #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output entry_t                   rdata_o
);

    entry_t mem_q [DEPTH];

    // cleared on reset so every tag starts invalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // combinational read where a write shows up after the edge
    assign rdata_o = mem_q[raddr_i];

endmodule

//--- cache_way.sv
// one cache way with tag and data arrays, tag compare and byte masked line write
`timescale 1ns/1ps

module cache_way (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  cache_types_pkg::way_cmd_t     cmd_i,
    input  logic                          we_i,
    output cache_types_pkg::way_resp_t    resp_o
);

    cache_types_pkg::tag_entry_t          entry_rd;
    cache_types_pkg::tag_entry_t          entry_wr;
    logic [cache_cfg_pkg::LINE_W-1:0]     line_rd;
    logic [cache_cfg_pkg::LINE_W-1:0]     line_wr;

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    // tag state per set
    cache_reg_array #(
        .entry_t (cache_types_pkg::tag_entry_t),
        .DEPTH   (cache_cfg_pkg::NUM_SETS)
    ) i_tag_array (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (we_i),
        .waddr_i (cmd_i.index),
        .wdata_i (entry_wr),
        .raddr_i (cmd_i.index),
        .rdata_o (entry_rd)
    );

    // line data per set
    cache_reg_array #(
        .entry_t (logic [cache_cfg_pkg::LINE_W-1:0]),
        .DEPTH   (cache_cfg_pkg::NUM_SETS)
    ) i_data_array (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .we_i    (we_i),
        .waddr_i (cmd_i.index),
        .wdata_i (line_wr),
        .raddr_i (cmd_i.index),
        .rdata_o (line_rd)
    );

    // merge new bytes over the stored line where a refill sets every mask bit
    always_comb begin
        for (int b = 0; b < cache_cfg_pkg::LINE_W / 8; b++) begin
            line_wr[b*8 +: 8] = cmd_i.be[b] ? cmd_i.wline[b*8 +: 8] : line_rd[b*8 +: 8];
        end
    end

    // store marks the line dirty and refill leaves it clean
    assign entry_wr.valid = cmd_i.valid;
    assign entry_wr.dirty = cmd_i.set_dirty;
    assign entry_wr.tag   = cmd_i.tag;

    // lookup result
    assign resp_o.hit   = entry_rd.valid && (entry_rd.tag == cmd_i.tag);
    assign resp_o.entry = entry_rd;
    assign resp_o.line  = line_rd;

endmodule

//--- cache_way_select.sv
// merges the way results into hit and line, and picks the round-robin victim
`timescale 1ns/1ps

module cache_way_select #(
    parameter int NUM_WAYS = 2
) (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  cache_types_pkg::way_resp_t [NUM_WAYS-1:0]  way_resp_i,
    input  logic                                       victim_adv_i,
    output logic                                       hit_o,
    output logic [NUM_WAYS-1:0]                        hit_way_o,
    output logic [cache_cfg_pkg::LINE_W-1:0]           hit_line_o,
    output logic [NUM_WAYS-1:0]                        victim_way_o,
    output cache_types_pkg::way_resp_t                 victim_o
);

    typedef logic [NUM_WAYS-1:0] way_vec_t;

    // one-hot round-robin pointer
    way_vec_t rr_q;

    // ------------------------------------------------------------------------
    // hit merge
    // ------------------------------------------------------------------------
    always_comb begin
        hit_line_o = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            hit_way_o[i] = way_resp_i[i].hit;
            // at most one way hits
            if (way_resp_i[i].hit) begin
                hit_line_o = way_resp_i[i].line;
            end
        end
    end

    assign hit_o = |hit_way_o;

    // ------------------------------------------------------------------------
    // victim choice
    // ------------------------------------------------------------------------
    always_comb begin
        victim_way_o = rr_q;
        // lowest invalid way wins over the pointer
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!way_resp_i[i].entry.valid) begin
                victim_way_o    = '0;
                victim_way_o[i] = 1'b1;
            end
        end
        victim_o = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (victim_way_o[i]) begin
                victim_o = way_resp_i[i];
            end
        end
    end

    // pointer rotates once per refill and starts at way 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= way_vec_t'(1);
        end else if (victim_adv_i) begin
            rr_q <= {rr_q[NUM_WAYS-2:0], rr_q[NUM_WAYS-1]};
        end
    end

endmodule

//--- cache_ctrl_fsm.sv
// blocking cache controller with lookup, two step store, write-back and refill
`timescale 1ns/1ps

module cache_ctrl_fsm #(
    parameter int NUM_WAYS = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // core port
    input  cache_types_pkg::core_req_t         core_req_i,
    output logic                               gnt_o,
    output cache_types_pkg::core_resp_t        core_resp_o,
    output logic                               busy_o,
    // memory port
    output cache_types_pkg::mem_req_t          mem_req_o,
    input  logic                               mem_ack_i,
    input  logic [cache_cfg_pkg::LINE_W-1:0]   mem_rline_i,
    // way command side
    output cache_types_pkg::way_cmd_t          way_cmd_o,
    output logic [NUM_WAYS-1:0]                way_we_o,
    output logic                               victim_adv_o,
    // selector results
    input  logic                               hit_i,
    input  logic [NUM_WAYS-1:0]                hit_way_i,
    input  logic [cache_cfg_pkg::LINE_W-1:0]   hit_line_i,
    input  logic [NUM_WAYS-1:0]                victim_way_i,
    input  cache_types_pkg::way_resp_t         victim_i
);

    // low address bits that pick a byte inside a word
    localparam int WORD_LSB = $clog2(cache_cfg_pkg::WORD_W / 8);
    // word select width inside a line
    localparam int WSEL_W = cache_cfg_pkg::OFFSET_W - WORD_LSB;

    typedef logic [cache_cfg_pkg::LINE_W-1:0]   line_t;
    typedef logic [cache_cfg_pkg::LINE_W/8-1:0] line_be_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        STORE_WRITE,
        WRITEBACK,
        REFILL
    } state_e;

    state_e                              state_d, state_q;
    // accepted request kept for the whole transaction
    cache_types_pkg::core_req_t          req_q;

    logic [cache_cfg_pkg::TAG_W-1:0]     req_tag;
    logic [cache_cfg_pkg::INDEX_W-1:0]   req_index;
    logic [WSEL_W-1:0]                   word_sel;

    // split the registered address
    assign req_tag   = req_q.addr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
    assign req_index = req_q.addr[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::INDEX_W];
    assign word_sel  = req_q.addr[cache_cfg_pkg::OFFSET_W-1:WORD_LSB];

    assign busy_o = (state_q != IDLE);

    // ------------------------------------------------------------------------
    // controller FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_d      = state_q;
        gnt_o        = 1'b0;
        core_resp_o  = '0;
        mem_req_o    = '0;
        way_we_o     = '0;
        victim_adv_o = 1'b0;
        // every way looks at the set of the held request
        way_cmd_o       = '0;
        way_cmd_o.index = req_index;
        way_cmd_o.tag   = req_tag;

        case (state_q)
            IDLE: begin
                // take a new request since the arrays are always ready
                if (core_req_i.valid) begin
                    gnt_o   = 1'b1;
                    state_d = LOOKUP;
                end
            end

            LOOKUP: begin
                if (hit_i) begin
                    if (req_q.we) begin
                        // store needs a second cycle to write the line
                        state_d = STORE_WRITE;
                    end else begin
                        core_resp_o.valid = 1'b1;
                        core_resp_o.rdata = hit_line_i[word_sel*cache_cfg_pkg::WORD_W +:
                                                       cache_cfg_pkg::WORD_W];
                        state_d = IDLE;
                    end
                end else if (victim_i.entry.valid && victim_i.entry.dirty) begin
                    // evict the dirty victim before the refill
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end

            STORE_WRITE: begin
                // set and tag are those of LOOKUP so the hit way still holds
                way_we_o            = hit_way_i;
                way_cmd_o.wline     = line_t'(req_q.wdata) << (word_sel * cache_cfg_pkg::WORD_W);
                way_cmd_o.be        = line_be_t'(req_q.be) << (word_sel * (2 ** WORD_LSB));
                way_cmd_o.set_dirty = 1'b1;
                way_cmd_o.valid     = 1'b1;
                core_resp_o.valid   = 1'b1;
                state_d             = IDLE;
            end

            WRITEBACK: begin
                // victim line stays put until the refill overwrites it
                mem_req_o.valid     = 1'b1;
                mem_req_o.we        = 1'b1;
                mem_req_o.line_addr = {victim_i.entry.tag, req_index};
                mem_req_o.wline     = victim_i.line;
                if (mem_ack_i) begin
                    state_d = REFILL;
                end
            end

            REFILL: begin
                mem_req_o.valid     = 1'b1;
                mem_req_o.line_addr = {req_tag, req_index};
                if (mem_ack_i) begin
                    // whole line, valid and clean, into the victim way
                    way_we_o            = victim_way_i;
                    way_cmd_o.wline     = mem_rline_i;
                    way_cmd_o.be        = '1;
                    way_cmd_o.valid     = 1'b1;
                    victim_adv_o        = 1'b1;
                    // repeat the lookup which now hits
                    state_d             = LOOKUP;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request payload loaded on grant
    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            req_q <= core_req_i;
        end
    end

endmodule

//--- cache_top.sv
// set-associative write-back data cache with controller, way array and way selector
`timescale 1ns/1ps

module cache_top #(
    parameter int NUM_WAYS = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // core port
    input  cache_types_pkg::core_req_t         core_req_i,
    output logic                               gnt_o,
    output cache_types_pkg::core_resp_t        core_resp_o,
    output logic                               busy_o,
    // memory port
    output cache_types_pkg::mem_req_t          mem_req_o,
    input  logic                               mem_ack_i,
    input  logic [cache_cfg_pkg::LINE_W-1:0]   mem_rline_i
);

    // command and per-way write enables from the controller
    cache_types_pkg::way_cmd_t                        way_cmd;
    logic [NUM_WAYS-1:0]                              way_we;
    // one lookup result per way
    cache_types_pkg::way_resp_t [NUM_WAYS-1:0]        way_resp;

    // selector outputs back to the controller
    logic                                             hit;
    logic [NUM_WAYS-1:0]                              hit_way;
    logic [cache_cfg_pkg::LINE_W-1:0]                 hit_line;
    logic [NUM_WAYS-1:0]                              victim_way;
    cache_types_pkg::way_resp_t                       victim;
    logic                                             victim_adv;

    // ------------------------------------------------------------------------
    // request controller
    // ------------------------------------------------------------------------
    cache_ctrl_fsm #(
        .NUM_WAYS (NUM_WAYS)
    ) i_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .core_req_i   (core_req_i),
        .gnt_o        (gnt_o),
        .core_resp_o  (core_resp_o),
        .busy_o       (busy_o),
        .mem_req_o    (mem_req_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rline_i  (mem_rline_i),
        .way_cmd_o    (way_cmd),
        .way_we_o     (way_we),
        .victim_adv_o (victim_adv),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .hit_line_i   (hit_line),
        .victim_way_i (victim_way),
        .victim_i     (victim)
    );

    // ------------------------------------------------------------------------
    // ways that all see the same command
    // ------------------------------------------------------------------------
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way i_way (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .cmd_i  (way_cmd),
            .we_i   (way_we[w]),
            .resp_o (way_resp[w])
        );
    end

    // hit merge and victim choice
    cache_way_select #(
        .NUM_WAYS (NUM_WAYS)
    ) i_way_select (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .way_resp_i   (way_resp),
        .victim_adv_i (victim_adv),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .hit_line_o   (hit_line),
        .victim_way_o (victim_way),
        .victim_o     (victim)
    );

endmodule

//--- cache_checker.sv
// protocol checks on the cache top level ports bound into the top
`timescale 1ns/1ps

module cache_checker (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  cache_types_pkg::core_req_t     core_req_i,
    input  logic                           gnt_o,
    input  cache_types_pkg::core_resp_t    core_resp_o,
    input  logic                           busy_o,
    input  cache_types_pkg::mem_req_t      mem_req_o,
    input  logic                           mem_ack_i
);

    localparam int LINE_A_W = cache_cfg_pkg::ADDR_W - cache_cfg_pkg::OFFSET_W;

    // count of failed assertions
    int                             fail_cnt = 0;

    logic                           pending_q;
    logic                           last_valid_q;
    logic [LINE_A_W-1:0]            last_line_q;
    logic                           load_rep_q;
    logic                           store_rep_q;
    logic                           store_rep_qq;
    logic                           mem_hold_q;
    cache_types_pkg::mem_req_t      mem_req_q;
    logic                           same_line;

    // request to the line of the previous granted request
    assign same_line = last_valid_q &&
                       (core_req_i.addr[cache_cfg_pkg::ADDR_W-1:cache_cfg_pkg::OFFSET_W] ==
                        last_line_q);

    // ------------------------------------------------------------------------
    // tracking state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q    <= 1'b0;
            last_valid_q <= 1'b0;
            last_line_q  <= '0;
            load_rep_q   <= 1'b0;
            store_rep_q  <= 1'b0;
            store_rep_qq <= 1'b0;
            mem_hold_q   <= 1'b0;
            mem_req_q    <= '0;
        end else begin
            if (gnt_o) begin
                pending_q    <= 1'b1;
                last_valid_q <= 1'b1;
                last_line_q  <= core_req_i.addr[cache_cfg_pkg::ADDR_W-1:cache_cfg_pkg::OFFSET_W];
            end else if (core_resp_o.valid) begin
                pending_q <= 1'b0;
            end
            load_rep_q   <= gnt_o && same_line && !core_req_i.we;
            store_rep_q  <= gnt_o && same_line && core_req_i.we;
            store_rep_qq <= store_rep_q;
            // memory request still open after this edge
            mem_hold_q   <= mem_req_o.valid && !mem_ack_i;
            mem_req_q    <= mem_req_o;
        end
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------
    gnt_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_o |-> core_req_i.valid && !busy_o)
        else begin
            fail_cnt++;
            $error("grant without a request or while busy");
        end

    idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !busy_o |-> !core_resp_o.valid && !mem_req_o.valid)
        else begin
            fail_cnt++;
            $error("response or memory request while idle");
        end

    mem_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_hold_q |-> mem_req_o.valid && (mem_req_o == mem_req_q))
        else begin
            fail_cnt++;
            $error("memory request changed before ack");
        end

    resp_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_resp_o.valid |-> pending_q)
        else begin
            fail_cnt++;
            $error("response without an open request");
        end

    gnt_after_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_o |-> !pending_q)
        else begin
            fail_cnt++;
            $error("new grant before the last response");
        end

    load_hit_time: assert property (@(posedge clk_i) disable iff (!rst_ni)
        load_rep_q |-> core_resp_o.valid)
        else begin
            fail_cnt++;
            $error("load hit did not respond one cycle after grant");
        end

    store_hit_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
        store_rep_q |-> !core_resp_o.valid)
        else begin
            fail_cnt++;
            $error("store hit responded one cycle after grant");
        end

    store_hit_time: assert property (@(posedge clk_i) disable iff (!rst_ni)
        store_rep_qq |-> core_resp_o.valid)
        else begin
            fail_cnt++;
            $error("store hit did not respond two cycles after grant");
        end

endmodule

//--- tb_cache_top.sv
// testbench for the set-associative cache with random loads and stores against a shadow memory
`timescale 1ns/1ps

module tb_cache_top;

    localparam int NUM_WAYS        = 2;
    localparam int NUM_TXN         = 300;
    // budget of 40 cycles per transaction plus reset and drain
    localparam int WATCHDOG_CYCLES = 40 * NUM_TXN + 20;
    localparam logic [31:0] SEED   = 32'h45c0_cf53;

    logic                                clk_i       = 1'b0;
    logic                                rst_ni      = 1'b0;
    cache_types_pkg::core_req_t          core_req_i  = '0;
    logic                                gnt_o;
    cache_types_pkg::core_resp_t         core_resp_o;
    logic                                busy_o;
    cache_types_pkg::mem_req_t           mem_req_o;
    logic                                mem_ack_i   = 1'b0;
    logic [cache_cfg_pkg::LINE_W-1:0]    mem_rline_i = '0;

    // expected word per {tag, set, word} of the test address space
    logic [31:0]                         shadow [128];
    // backing memory per {tag, set} line
    logic [cache_cfg_pkg::LINE_W-1:0]    mem_lines [32];
    logic [31:0]                         stim_state = SEED;
    logic [31:0]                         lat_state  = ~SEED;
    logic [1:0]                          mem_wait   = '0;
    logic                                mem_busy   = 1'b0;
    int                                  err_cnt    = 0;
    // last line used so that some requests revisit it
    logic [2:0]                          prev_tag   = '0;
    logic [1:0]                          prev_set   = '0;

    always #10 clk_i = ~clk_i;

    cache_top #(
        .NUM_WAYS (NUM_WAYS)
    ) UUT (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .core_req_i  (core_req_i),
        .gnt_o       (gnt_o),
        .core_resp_o (core_resp_o),
        .busy_o      (busy_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rline_i (mem_rline_i)
    );

    bind cache_top cache_checker i_checker (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .core_req_i  (core_req_i),
        .gnt_o       (gnt_o),
        .core_resp_o (core_resp_o),
        .busy_o      (busy_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_idle_outputs(input string phase);
        assert (!gnt_o && !busy_o && !core_resp_o.valid && !mem_req_o.valid) else begin
            err_cnt++;
            $display("ERR %0t ns: outputs not idle during %s", $time, phase);
        end
    endtask

    // ------------------------------------------------------------------------
    // drive one request and wait for its grant and its response pulse
    // ------------------------------------------------------------------------
    task automatic issue_request();
        logic [31:0]                 ctl;
        logic [2:0]                  tag_sel;
        logic [1:0]                  set_sel;
        logic [1:0]                  word_sel;
        logic [6:0]                  key;
        logic [31:0]                 expected;
        cache_types_pkg::core_req_t  req;
        stim_state = xorshift32(stim_state);
        ctl        = stim_state;
        stim_state = xorshift32(stim_state);
        // one in four revisits the previous line
        tag_sel  = (ctl[13:12] == 2'b00) ? prev_tag : ctl[2:0];
        set_sel  = (ctl[13:12] == 2'b00) ? prev_set : ctl[4:3];
        word_sel = ctl[6:5];
        prev_tag = tag_sel;
        prev_set = set_sel;
        key      = {tag_sel, set_sel, word_sel};
        req.valid = 1'b1;
        req.we    = ctl[7];
        req.addr  = {21'd0, tag_sel, 2'b00, set_sel, word_sel, 2'b00};
        req.be    = (ctl[11:8] == 4'h0) ? 4'hf : ctl[11:8];
        req.wdata = stim_state;
        core_req_i = req;
        // held as a level until the controller grants it
        #1;
        while (!gnt_o) begin
            @(posedge clk_i);
            #2;
        end
        expected = shadow[key];
        if (req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) begin
                    shadow[key][b*8 +: 8] = req.wdata[b*8 +: 8];
                end
            end
        end
        @(posedge clk_i);
        #1;
        core_req_i = '0;
        while (!core_resp_o.valid) begin
            @(posedge clk_i);
            #1;
        end
        if (!req.we) begin
            assert (core_resp_o.rdata == expected) else begin
                err_cnt++;
                $display("ERR %0t ns: load %h returned %h, expected %h",
                         $time, req.addr, core_resp_o.rdata, expected);
            end
        end else begin
            assert (core_resp_o.rdata == '0) else begin
                err_cnt++;
                $display("ERR %0t ns: store %h returned nonzero rdata %h",
                         $time, req.addr, core_resp_o.rdata);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // memory model with a random ack latency of 1 to 4 cycles
    // ------------------------------------------------------------------------
    initial begin
        logic [4:0] mkey;
        for (int i = 0; i < 32; i++) begin
            mem_lines[i] = '0;
        end
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_ack_i) begin
                // strobe was taken at this edge
                mem_ack_i = 1'b0;
            end else if (mem_req_o.valid) begin
                if (!mem_busy) begin
                    lat_state = xorshift32(lat_state);
                    mem_wait  = lat_state[1:0];
                    mem_busy  = 1'b1;
                end
                if (mem_wait == 2'd0) begin
                    mkey = {mem_req_o.line_addr[6:4], mem_req_o.line_addr[1:0]};
                    if (mem_req_o.we) begin
                        mem_lines[mkey] = mem_req_o.wline;
                    end else begin
                        mem_rline_i = mem_lines[mkey];
                    end
                    mem_ack_i = 1'b1;
                    mem_busy  = 1'b0;
                end else begin
                    mem_wait = mem_wait - 2'd1;
                end
            end
        end
    end

    // main sequence
    initial begin
        int total;
        for (int i = 0; i < 128; i++) begin
            shadow[i] = '0;
        end
        repeat (2) begin
            @(posedge clk_i);
            #1;
            check_idle_outputs("reset");
        end
        rst_ni = 1'b1;
        repeat (3) begin
            @(posedge clk_i);
            #1;
            check_idle_outputs("idle after reset");
        end
        for (int n = 0; n < NUM_TXN; n++) begin
            issue_request();
        end
        repeat (2) @(posedge clk_i);
        total = err_cnt + UUT.i_checker.fail_cnt;
        $display("errors: %0d data, %0d protocol", err_cnt, UUT.i_checker.fail_cnt);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sources.f
cache_cfg_pkg.sv
cache_types_pkg.sv
cache_reg_array.sv
cache_way.sv
cache_way_select.sv
cache_ctrl_fsm.sv
cache_top.sv
cache_checker.sv
tb_cache_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cache_top \
    -f sources.f -o tb_cache_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# raise the error limit so every failed check is counted before the summary
./obj_dir/tb_cache_top +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
